/* rtl/spi_async_fifo.sv */
// Dual-clock FIFO with Gray-coded pointers and two-flop synchronizers.
// The read port is show-ahead, so rd_data holds the head while empty is low.
// rst_sclk_n resets the write side, arst_n the read side.

`timescale 1ns/1ns
`default_nettype none

module spi_async_fifo (
    // Write side.
    input  logic                  wr_clk,
    input  logic                  wr_en,
    input  spi_sub_pkg::spi_word_t wr_data,
    output logic                  full,
    // Read side.
    input  logic                  rd_clk,
    input  logic                  rd_en,
    output spi_sub_pkg::spi_word_t rd_data,
    output logic                  empty,
    // Resets.
    input  logic                  arst_n,
    input  logic                  rst_sclk_n
);
    import spi_sub_pkg::*;

    // Storage, no reset needed.
    spi_word_t mem [spi_fifo_depth];

    // Write domain pointers.
    logic [spi_fifo_ptr_w-1:0] wr_bin;
    logic [spi_fifo_ptr_w-1:0] wr_bin_next;
    logic [spi_fifo_ptr_w-1:0] wr_gray;
    // Read pointer seen from the write domain.
    logic [spi_fifo_ptr_w-1:0] rd_gray_w1;
    logic [spi_fifo_ptr_w-1:0] rd_gray_w2;

    // Read domain pointers.
    logic [spi_fifo_ptr_w-1:0] rd_bin;
    logic [spi_fifo_ptr_w-1:0] rd_bin_next;
    logic [spi_fifo_ptr_w-1:0] rd_gray;
    // Write pointer seen from the read domain.
    logic [spi_fifo_ptr_w-1:0] wr_gray_r1;
    logic [spi_fifo_ptr_w-1:0] wr_gray_r2;

    logic wr_fire;
    logic rd_fire;

    ////////////////////////////////////////////////////////////
    // Write side.
    ////////////////////////////////////////////////////////////

    // Writes into a full FIFO are ignored.
    assign wr_fire     = wr_en & ~full;
    assign wr_bin_next = wr_bin + 1'b1;

    always_ff @(posedge wr_clk or negedge rst_sclk_n) begin
        if (!rst_sclk_n) begin
            wr_bin  <= '0;
            wr_gray <= '0;
        end else if (wr_fire) begin
            wr_bin  <= wr_bin_next;
            wr_gray <= (wr_bin_next >> 1) ^ wr_bin_next;
        end
    end

    always_ff @(posedge wr_clk) begin
        if (wr_fire) begin
            mem[wr_bin[spi_fifo_ptr_w-2:0]] <= wr_data;
        end
    end

    // Bring the read pointer over.
    always_ff @(posedge wr_clk or negedge rst_sclk_n) begin
        if (!rst_sclk_n) begin
            rd_gray_w1 <= '0;
            rd_gray_w2 <= '0;
        end else begin
            rd_gray_w1 <= rd_gray;
            rd_gray_w2 <= rd_gray_w1;
        end
    end

    // Full when the top two Gray bits differ and the rest match.
    assign full = (wr_gray == {~rd_gray_w2[spi_fifo_ptr_w-1 -: 2],
                               rd_gray_w2[spi_fifo_ptr_w-3:0]});

    ////////////////////////////////////////////////////////////
    // Read side.
    ////////////////////////////////////////////////////////////

    assign rd_fire     = rd_en & ~empty;
    assign rd_bin_next = rd_bin + 1'b1;

    always_ff @(posedge rd_clk or negedge arst_n) begin
        if (!arst_n) begin
            rd_bin  <= '0;
            rd_gray <= '0;
        end else if (rd_fire) begin
            rd_bin  <= rd_bin_next;
            rd_gray <= (rd_bin_next >> 1) ^ rd_bin_next;
        end
    end

    // Bring the write pointer over.
    always_ff @(posedge rd_clk or negedge arst_n) begin
        if (!arst_n) begin
            wr_gray_r1 <= '0;
            wr_gray_r2 <= '0;
        end else begin
            wr_gray_r1 <= wr_gray;
            wr_gray_r2 <= wr_gray_r1;
        end
    end

    assign empty = (rd_gray == wr_gray_r2);

    // Show-ahead head of the queue.
    assign rd_data = mem[rd_bin[spi_fifo_ptr_w-2:0]];

endmodule

`default_nettype wire

/* rtl/spi_rx_deserializer.sv */
// Shifts mosi into words on the rising edge of sclk.
// word_done and word are combinational, valid in the cycle of the last bit,
// so a word is stored on the same sclk edge that carries its last bit.

`timescale 1ns/1ns
`default_nettype none

module spi_rx_deserializer (
    input  logic                   sclk,
    input  logic                   rst_n,
    input  logic                   mosi,
    input  logic                   lsb_first,
    output logic                   word_done,
    output spi_sub_pkg::spi_word_t word
);
    import spi_sub_pkg::*;

    spi_word_t              shift_q;
    logic [spi_bit_cnt_w-1:0] bit_cnt;

    // MSB first enters at the bottom, LSB first enters at the top.
    assign word = lsb_first ? {mosi, shift_q[spi_word_w-1:1]}
                            : {shift_q[spi_word_w-2:0], mosi};

    // Last bit of the word.
    assign word_done = (bit_cnt == spi_bit_cnt_w'(spi_word_w - 1));

    always_ff @(posedge sclk or negedge rst_n) begin
        if (!rst_n) begin
            bit_cnt <= '0;
        end else begin
            // Wraps back to zero after the last bit.
            bit_cnt <= bit_cnt + 1'b1;
        end
    end

    // Shift data needs no reset, the counter frames it.
    always_ff @(posedge sclk) begin
        shift_q <= word;
    end

endmodule

`default_nettype wire

/* rtl/spi_sub_core.sv */
// SPI sub datapath: receive and transmit FIFOs plus the two shifters.
// The shifters restart on every select; the FIFOs only on arst_n.
// Control inputs are quasi-static and change only while ssn is high.

`timescale 1ns/1ns
`default_nettype none

module spi_sub_core (
    // SPI pins.
    input  logic                   sclk,
    input  logic                   ssn,
    input  logic                   mosi,
    output logic                   miso,
    // System.
    input  logic                   sys_clk,
    input  logic                   arst_n,
    // Settings from the register block.
    input  spi_sub_pkg::spi_ctrl_t ctrl,
    input  spi_sub_pkg::spi_word_t idle_word,
    // Transmit stream.
    input  logic                   tx_valid,
    input  spi_sub_pkg::spi_word_t tx_data,
    output logic                   tx_ready,
    // Receive stream.
    output logic                   rx_valid,
    output spi_sub_pkg::spi_word_t rx_data,
    input  logic                   rx_ready,
    // Select state in sys_clk.
    output logic                   active
);
    import spi_sub_pkg::*;

    logic      sclk_rst_n;
    logic [1:0] active_sync;

    logic      rx_word_done;
    spi_word_t rx_word;
    logic      rx_wr_en;
    logic      rx_full;
    logic      rx_empty;

    spi_word_t tx_head;
    logic      tx_full;
    logic      tx_empty;
    logic      tx_pop_sclk;
    logic [2:0] tx_pop_sync;
    logic      tx_pop;

    // Shifters are held in reset while deselected.
    assign sclk_rst_n = arst_n & ~ssn;

    always_ff @(posedge sys_clk or negedge arst_n) begin
        if (!arst_n) begin
            active_sync <= '0;
        end else begin
            active_sync <= {active_sync[0], ~ssn};
        end
    end

    assign active = active_sync[1];

    ////////////////////////////////////////////////////////////
    // Receive path.
    ////////////////////////////////////////////////////////////

    spi_rx_deserializer u_rx_deser (
        .sclk      (sclk),
        .rst_n     (sclk_rst_n),
        .mosi      (mosi),
        .lsb_first (ctrl.lsb_first),
        .word_done (rx_word_done),
        .word      (rx_word)
    );

    // Words that find the FIFO full are lost.
    assign rx_wr_en = rx_word_done & ctrl.enable & ~rx_full;

    // Write pointer lives in sclk and must survive deselect.
    spi_async_fifo u_rx_fifo (
        .wr_clk     (sclk),
        .wr_en      (rx_wr_en),
        .wr_data    (rx_word),
        .full       (rx_full),
        .rd_clk     (sys_clk),
        .rd_en      (rx_ready),
        .rd_data    (rx_data),
        .empty      (rx_empty),
        .arst_n     (arst_n),
        .rst_sclk_n (arst_n)
    );

    assign rx_valid = ~rx_empty;

    ////////////////////////////////////////////////////////////
    // Transmit path.
    ////////////////////////////////////////////////////////////

    // Both pointers run on sys_clk, sclk is idle between transfers.
    // The head is sampled by sclk, and the pop returns through a synchronizer.
    spi_async_fifo u_tx_fifo (
        .wr_clk     (sys_clk),
        .wr_en      (tx_valid),
        .wr_data    (tx_data),
        .full       (tx_full),
        .rd_clk     (sys_clk),
        .rd_en      (tx_pop),
        .rd_data    (tx_head),
        .empty      (tx_empty),
        .arst_n     (arst_n),
        .rst_sclk_n (arst_n)
    );

    assign tx_ready = ~tx_full;

    // Disabled core sends the idle word and keeps its data.
    spi_tx_serializer u_tx_ser (
        .sclk       (sclk),
        .rst_n      (sclk_rst_n),
        .lsb_first  (ctrl.lsb_first),
        .head       (tx_head),
        .head_valid (~tx_empty & ctrl.enable),
        .idle_word  (idle_word),
        .pop        (tx_pop_sclk),
        .miso       (miso)
    );

    // Two sync flops, then rising edge detect.
    always_ff @(posedge sys_clk or negedge arst_n) begin
        if (!arst_n) begin
            tx_pop_sync <= '0;
        end else begin
            tx_pop_sync <= {tx_pop_sync[1:0], tx_pop_sclk};
        end
    end

    assign tx_pop = tx_pop_sync[1] & ~tx_pop_sync[2];

endmodule

`default_nettype wire

/* rtl/spi_sub_pkg.sv */
// Shared types and constants for the SPI sub peripheral.
// Word size, FIFO depth, register map and register word layouts.
// Every RTL file of the peripheral imports this package.

`default_nettype none

package spi_sub_pkg;

    ////////////////////////////////////////////////////////////
    // Sizes.
    ////////////////////////////////////////////////////////////

    // Bits per SPI word.
    localparam int spi_word_w = 8;
    // Bits of the per-word bit counter in the sclk domain.
    localparam int spi_bit_cnt_w = $clog2(spi_word_w);
    // Entries per FIFO, a power of two.
    localparam int spi_fifo_depth = 4;
    // Pointer width, one extra bit to tell full from empty.
    localparam int spi_fifo_ptr_w = $clog2(spi_fifo_depth) + 1;

    // One SPI word.
    typedef logic [spi_word_w-1:0] spi_word_t;

    ////////////////////////////////////////////////////////////
    // Register map.
    ////////////////////////////////////////////////////////////

    typedef logic [1:0] spi_reg_addr_t;

    localparam spi_reg_addr_t reg_addr_ctrl   = 2'd0;
    localparam spi_reg_addr_t reg_addr_idle   = 2'd1;
    // Read-only.
    localparam spi_reg_addr_t reg_addr_status = 2'd2;

    // Control register layout, enable in bit zero.
    typedef struct packed {
        logic [spi_word_w-3:0] reserved;
        logic                  lsb_first;
        logic                  enable;
    } spi_ctrl_t;

    // Status register layout, active in bit zero.
    typedef struct packed {
        logic [spi_word_w-4:0] reserved;
        logic                  tx_ready;
        logic                  rx_valid;
        logic                  active;
    } spi_status_t;

    // A written register word, decoded by address.
    // Control fields at the control address, a plain word at the idle address.
    typedef union packed {
        spi_ctrl_t ctrl;
        spi_word_t word;
    } spi_reg_word_u;

endpackage

`default_nettype wire

/* rtl/spi_sub_regs.sv */
// Host register block with a four-phase req/ack port.
// Holds control and idle word, and reads back status.
// Each request is served once, on the edge where req is first seen high.

`timescale 1ns/1ns
`default_nettype none

module spi_sub_regs (
    input  logic                       sys_clk,
    input  logic                       arst_n,
    // Four-phase register port.
    input  logic                       reg_req,
    input  logic                       reg_we,
    input  spi_sub_pkg::spi_reg_addr_t reg_addr,
    input  spi_sub_pkg::spi_reg_word_u reg_wdata,
    output logic                       reg_ack,
    output spi_sub_pkg::spi_word_t     reg_rdata,
    // Status inputs.
    input  logic                       active,
    input  logic                       rx_valid,
    input  logic                       tx_ready,
    // Settings for the core.
    output spi_sub_pkg::spi_ctrl_t     ctrl,
    output spi_sub_pkg::spi_word_t     idle_word
);
    import spi_sub_pkg::*;

    logic        req_rise;
    spi_status_t status;
    spi_word_t   rd_word;

    // Req high while ack still low marks a new request.
    assign req_rise = reg_req & ~reg_ack;

    assign status = '{
        reserved: '0,
        tx_ready: tx_ready,
        rx_valid: rx_valid,
        active:   active
    };

    // Read mux.
    always_comb begin
        case (reg_addr)
            reg_addr_ctrl:   rd_word = ctrl;
            reg_addr_idle:   rd_word = idle_word;
            reg_addr_status: rd_word = status;
            default:         rd_word = '0;
        endcase
    end

    ////////////////////////////////////////////////////////////
    // Handshake and registers.
    ////////////////////////////////////////////////////////////

    // Ack follows req one edge later in both directions.
    always_ff @(posedge sys_clk or negedge arst_n) begin
        if (!arst_n) begin
            reg_ack <= 1'b0;
        end else begin
            reg_ack <= reg_req;
        end
    end

    always_ff @(posedge sys_clk or negedge arst_n) begin
        if (!arst_n) begin
            ctrl      <= '{reserved: '0, lsb_first: 1'b0, enable: 1'b1};
            idle_word <= '0;
        end else if (req_rise && reg_we) begin
            case (reg_addr)
                // Reserved control bits always read as zero.
                reg_addr_ctrl: begin
                    ctrl <= '{
                        reserved:  '0,
                        lsb_first: reg_wdata.ctrl.lsb_first,
                        enable:    reg_wdata.ctrl.enable
                    };
                end
                reg_addr_idle: idle_word <= reg_wdata.word;
                default: ;
            endcase
        end
    end

    // Read data captured with the request, held while ack is high.
    always_ff @(posedge sys_clk) begin
        if (req_rise) begin
            reg_rdata <= rd_word;
        end
    end

endmodule

`default_nettype wire

/* rtl/spi_sub_top.sv */
// Top of the SPI sub peripheral, mode 0.
// Connects the register block to the core and exposes SPI,
// stream and register ports.

`timescale 1ns/1ns
`default_nettype none

module spi_sub_top (
    // SPI.
    input  logic                       sclk,
    input  logic                       ssn,
    input  logic                       mosi,
    output logic                       miso,
    // System.
    input  logic                       sys_clk,
    input  logic                       arst_n,
    // Transmit stream.
    input  logic                       tx_valid,
    input  spi_sub_pkg::spi_word_t     tx_data,
    output logic                       tx_ready,
    // Receive stream.
    output logic                       rx_valid,
    output spi_sub_pkg::spi_word_t     rx_data,
    input  logic                       rx_ready,
    // Register port.
    input  logic                       reg_req,
    input  logic                       reg_we,
    input  spi_sub_pkg::spi_reg_addr_t reg_addr,
    input  spi_sub_pkg::spi_reg_word_u reg_wdata,
    output logic                       reg_ack,
    output spi_sub_pkg::spi_word_t     reg_rdata
);
    import spi_sub_pkg::*;

    spi_ctrl_t ctrl;
    spi_word_t idle_word;
    logic      active;

    spi_sub_regs u_regs (
        .sys_clk   (sys_clk),
        .arst_n    (arst_n),
        .reg_req   (reg_req),
        .reg_we    (reg_we),
        .reg_addr  (reg_addr),
        .reg_wdata (reg_wdata),
        .reg_ack   (reg_ack),
        .reg_rdata (reg_rdata),
        .active    (active),
        .rx_valid  (rx_valid),
        .tx_ready  (tx_ready),
        .ctrl      (ctrl),
        .idle_word (idle_word)
    );

    spi_sub_core u_core (
        .sclk      (sclk),
        .ssn       (ssn),
        .mosi      (mosi),
        .miso      (miso),
        .sys_clk   (sys_clk),
        .arst_n    (arst_n),
        .ctrl      (ctrl),
        .idle_word (idle_word),
        .tx_valid  (tx_valid),
        .tx_data   (tx_data),
        .tx_ready  (tx_ready),
        .rx_valid  (rx_valid),
        .rx_data   (rx_data),
        .rx_ready  (rx_ready),
        .active    (active)
    );

endmodule

`default_nettype wire

/* rtl/spi_tx_serializer.sv */
// Drives miso for SPI mode 0, changing it on the falling edge of sclk.
// Bit zero of a word comes straight from the FIFO head or the idle word.
// The first falling edge latches the word and pops the head if it was used.

`timescale 1ns/1ns
`default_nettype none

module spi_tx_serializer (
    input  logic                   sclk,
    input  logic                   rst_n,
    input  logic                   lsb_first,
    input  spi_sub_pkg::spi_word_t head,
    input  logic                   head_valid,
    input  spi_sub_pkg::spi_word_t idle_word,
    output logic                   pop,
    output logic                   miso
);
    import spi_sub_pkg::*;

    spi_word_t                cur_word;
    spi_word_t                latch_q;
    logic [spi_bit_cnt_w-1:0] bit_cnt;

    // Word for this slot, the idle word on underrun.
    assign cur_word = head_valid ? head : idle_word;

    // First bit from the live word, later bits from the latch.
    always_comb begin
        if (bit_cnt == '0) begin
            miso = lsb_first ? cur_word[0] : cur_word[spi_word_w-1];
        end else begin
            miso = lsb_first ? latch_q[0] : latch_q[spi_word_w-1];
        end
    end

    always_ff @(negedge sclk or negedge rst_n) begin
        if (!rst_n) begin
            bit_cnt <= '0;
            pop     <= 1'b0;
        end else begin
            bit_cnt <= bit_cnt + 1'b1;
            // One sclk period wide, so the sys_clk side can catch it.
            pop     <= (bit_cnt == '0) & head_valid;
        end
    end

    // Next bit moves into the position miso reads.
    always_ff @(negedge sclk) begin
        if (bit_cnt == '0) begin
            latch_q <= lsb_first ? (cur_word >> 1) : (cur_word << 1);
        end else begin
            latch_q <= lsb_first ? (latch_q >> 1) : (latch_q << 1);
        end
    end

endmodule

`default_nettype wire

/* run.sh */
#!/bin/sh
# Builds and runs the SPI sub testbench with Verilator.
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert -Wno-fatal --top-module spi_sub_tb -f vlog.f || exit 1
out=$(./obj_dir/Vspi_sub_tb +verilator+error+limit+1000)
echo "$out"
echo "$out" | grep -qx "SIMULATION PASSED" && echo "run ok" || { echo "run not ok"; exit 1; }

/* tests/spi_sub_props.sv */
// Concurrent checks on the register handshake, the rx stream and miso.
// Bound to the SPI sub top level.

`timescale 1ns/1ns
`default_nettype none

module spi_sub_props (
    input logic                   sys_clk,
    input logic                   arst_n,
    input logic                   reg_req,
    input logic                   reg_ack,
    input logic                   rx_valid,
    input logic                   rx_ready,
    input spi_sub_pkg::spi_word_t rx_data,
    input logic                   sclk,
    input logic                   ssn,
    input logic                   miso
);
    // Read by the testbench at the end of the run.
    int unsigned fail_count = 0;

    ////////////////////////////////////////////////////////////
    // Register handshake.
    ////////////////////////////////////////////////////////////

    ack_rise_a: assert property (@(posedge sys_clk) disable iff (!arst_n)
        $rose(reg_ack) |-> $past(reg_req))
        else begin
            fail_count++;
            $error("reg_ack rose while reg_req was low");
        end

    ack_fall_a: assert property (@(posedge sys_clk) disable iff (!arst_n)
        $fell(reg_ack) |-> !$past(reg_req))
        else begin
            fail_count++;
            $error("reg_ack fell while reg_req was high");
        end

    // Stalled rx word holds.
    rx_hold_a: assert property (@(posedge sys_clk) disable iff (!arst_n)
        (rx_valid && !rx_ready) |=> (rx_valid && $stable(rx_data)))
        else begin
            fail_count++;
            $error("rx word changed or vanished while stalled");
        end

    // Miso only moves on falling sclk in mode 0.
    // The first sample with sclk high is compared with the last one before the rise.
    miso_hold_a: assert property (@(posedge sys_clk) disable iff (!arst_n)
        (sclk && !ssn && !$past(ssn)) |-> $stable(miso))
        else begin
            fail_count++;
            $error("miso changed at or after the rising sclk edge");
        end

endmodule

bind spi_sub_top spi_sub_props u_props (
    .sys_clk  (sys_clk),
    .arst_n   (arst_n),
    .reg_req  (reg_req),
    .reg_ack  (reg_ack),
    .rx_valid (rx_valid),
    .rx_ready (rx_ready),
    .rx_data  (rx_data),
    .sclk     (sclk),
    .ssn      (ssn),
    .miso     (miso)
);

`default_nettype wire

/* tests/spi_sub_tb.sv */
// Testbench for the SPI sub peripheral.
// Acts as SPI main, register host and stream partner, and checks six behaviors
// with immediate asserts. Concurrent checks come from the bound props module.

`timescale 1ns/1ns
`default_nettype none

module spi_sub_tb;
    import spi_sub_pkg::*;

    // One SPI word with select and gap, in sys_clk cycles.
    localparam int xfer_cycles = 40;
    localparam int n_xfers     = 20;
    // Room for register, stream and idle phases between words.
    localparam int watchdog_ns = (n_xfers * (xfer_cycles + 30) + 600) * 20;

    logic          sys_clk;
    logic          arst_n;
    logic          sclk;
    logic          ssn;
    logic          mosi;
    logic          miso;
    logic          tx_valid;
    spi_word_t     tx_data;
    logic          tx_ready;
    logic          rx_valid;
    spi_word_t     rx_data;
    logic          rx_ready;
    logic          reg_req;
    logic          reg_we;
    spi_reg_addr_t reg_addr;
    spi_reg_word_u reg_wdata;
    logic          reg_ack;
    spi_word_t     reg_rdata;

    int    errors       = 0;
    int    checks       = 0;
    int    tests_run    = 0;
    int    tests_failed = 0;
    int    test_err_base;
    string test_name;

    spi_sub_top UUT (.*);

    initial begin
        sys_clk = 1'b0;
        forever #10 sys_clk = ~sys_clk;
    end

    initial begin : watchdog
        #(watchdog_ns);
        $display("Watchdog expired after %0d ns, the run is stuck", watchdog_ns);
        $display("SIMULATION FAILED");
        $finish;
    end

    ////////////////////////////////////////////////////////////
    // Checks and bookkeeping.
    ////////////////////////////////////////////////////////////

    task automatic begin_test(input string name);
        test_name     = name;
        test_err_base = errors;
    endtask

    task automatic end_test();
        tests_run++;
        if (errors == test_err_base) begin
            $display("Test %s: pass", test_name);
        end else begin
            tests_failed++;
            $display("Test %s: FAIL with %0d errors", test_name, errors - test_err_base);
        end
    endtask

    task automatic check_word(input spi_word_t exp, input spi_word_t act);
        checks++;
        assert (act === exp) else begin
            errors++;
            $display("Mismatch in %s: expected 8'h%02h, actual 8'h%02h", test_name, exp, act);
        end
    endtask

    task automatic check_cond(input logic ok, input string what);
        checks++;
        assert (ok) else begin
            errors++;
            $display("Error in %s: %s", test_name, what);
        end
    endtask

    // Bit sequence on the wire, first bit in bit 7.
    function automatic spi_word_t wire_order(input spi_word_t word, input logic lsb);
        spi_word_t rev;
        for (int i = 0; i < spi_word_w; i++) begin
            rev[spi_word_w-1-i] = word[i];
        end
        return lsb ? rev : word;
    endfunction

    function automatic spi_word_t rand_word();
        return spi_word_t'($urandom);
    endfunction

    ////////////////////////////////////////////////////////////
    // Register port and streams.
    ////////////////////////////////////////////////////////////

    task automatic wait_ack(input logic level);
        int n;
        n = 0;
        while (reg_ack !== level && n < 16) begin
            @(negedge sys_clk);
            n++;
        end
        check_cond(reg_ack === level, "register handshake timed out");
    endtask

    task automatic reg_access(input logic we, input spi_reg_addr_t addr,
                              input spi_word_t wdata, output spi_word_t rdata);
        @(negedge sys_clk);
        reg_we         = we;
        reg_addr       = addr;
        reg_wdata.word = wdata;
        reg_req        = 1'b1;
        wait_ack(1'b1);
        rdata   = reg_rdata;
        reg_req = 1'b0;
        wait_ack(1'b0);
    endtask

    task automatic push_tx(input spi_word_t data);
        int n;
        n = 0;
        @(negedge sys_clk);
        tx_valid = 1'b1;
        tx_data  = data;
        // Ready seen here holds until the next rising edge.
        while (!tx_ready && n < 64) begin
            @(negedge sys_clk);
            n++;
        end
        check_cond(tx_ready, "tx stream never became ready");
        @(negedge sys_clk);
        tx_valid = 1'b0;
    endtask

    task automatic pop_rx(output spi_word_t data);
        int n;
        n = 0;
        @(negedge sys_clk);
        while (!rx_valid && n < 16) begin
            @(negedge sys_clk);
            n++;
        end
        check_cond(rx_valid, "no word arrived on the rx stream");
        data     = rx_data;
        rx_ready = 1'b1;
        @(negedge sys_clk);
        rx_ready = 1'b0;
    endtask

    task automatic expect_no_rx(input int cycles);
        logic seen;
        seen = 1'b0;
        repeat (cycles) begin
            @(negedge sys_clk);
            seen = seen | rx_valid;
        end
        check_cond(!seen, "rx_valid rose for a word that should not arrive");
    endtask

    ////////////////////////////////////////////////////////////
    // SPI main, mode 0, one word per select.
    ////////////////////////////////////////////////////////////

    task automatic spi_xfer(input spi_word_t out_bits, output spi_word_t in_bits);
        @(negedge sys_clk);
        ssn  = 1'b0;
        mosi = out_bits[spi_word_w-1];
        for (int i = spi_word_w - 1; i >= 0; i--) begin
            repeat (2) @(negedge sys_clk);
            // Miso only moves on falling sclk, so it is settled here.
            in_bits[i] = miso;
            sclk = 1'b1;
            repeat (2) @(negedge sys_clk);
            sclk = 1'b0;
            if (i > 0) begin
                mosi = out_bits[i-1];
            end
        end
        repeat (2) @(negedge sys_clk);
        ssn = 1'b1;
        repeat (4) @(negedge sys_clk);
    endtask

    // One word each way, then the received side is checked.
    task automatic exchange(input spi_word_t send, input spi_word_t exp_miso,
                            input logic lsb, input logic expect_rx);
        spi_word_t seen;
        spi_word_t got;
        spi_xfer(wire_order(send, lsb), seen);
        check_word(wire_order(exp_miso, lsb), seen);
        if (expect_rx) begin
            pop_rx(got);
            check_word(send, got);
        end else begin
            expect_no_rx(12);
        end
    endtask

    ////////////////////////////////////////////////////////////
    // Test sequence.
    ////////////////////////////////////////////////////////////

    initial begin : main
        spi_word_t   w;
        spi_word_t   rd;
        spi_word_t   idle_val;
        spi_ctrl_t   exp_ctrl;
        spi_status_t exp_status;
        spi_word_t   tx_q[$];
        spi_word_t   sent_q[$];
        int          total_err;

        void'($urandom(32'h465a));
        arst_n    = 1'b0;
        sclk      = 1'b0;
        ssn       = 1'b1;
        mosi      = 1'b0;
        tx_valid  = 1'b0;
        tx_data   = '0;
        rx_ready  = 1'b0;
        reg_req   = 1'b0;
        reg_we    = 1'b0;
        reg_addr  = reg_addr_ctrl;
        reg_wdata = '0;
        repeat (4) @(negedge sys_clk);
        arst_n = 1'b1;
        repeat (2) @(negedge sys_clk);

        // Reset values, then write and read back.
        begin_test("reg_readback");
        exp_status          = '0;
        exp_status.tx_ready = 1'b1;
        reg_access(1'b0, reg_addr_status, '0, rd);
        check_word(exp_status, rd);
        exp_ctrl        = '0;
        exp_ctrl.enable = 1'b1;
        reg_access(1'b0, reg_addr_ctrl, '0, rd);
        check_word(exp_ctrl, rd);
        reg_access(1'b0, reg_addr_idle, '0, rd);
        check_word('0, rd);
        exp_ctrl.lsb_first = 1'b1;
        reg_access(1'b1, reg_addr_ctrl, exp_ctrl, rd);
        reg_access(1'b0, reg_addr_ctrl, '0, rd);
        check_word(exp_ctrl, rd);
        exp_ctrl.lsb_first = 1'b0;
        reg_access(1'b1, reg_addr_ctrl, exp_ctrl, rd);
        reg_access(1'b0, reg_addr_ctrl, '0, rd);
        check_word(exp_ctrl, rd);
        idle_val = rand_word();
        reg_access(1'b1, reg_addr_idle, idle_val, rd);
        reg_access(1'b0, reg_addr_idle, '0, rd);
        check_word(idle_val, rd);
        end_test();

        // Empty transmit FIFO, so miso carries the idle word.
        begin_test("rx_msb");
        repeat (5) begin
            exchange(rand_word(), idle_val, 1'b0, 1'b1);
        end
        end_test();

        begin_test("tx_msb");
        repeat (3) begin
            w = rand_word();
            tx_q.push_back(w);
            push_tx(w);
        end
        // Write pointer crossing, about three cycles.
        repeat (6) @(negedge sys_clk);
        foreach (tx_q[k]) begin
            exchange(rand_word(), tx_q[k], 1'b0, 1'b1);
        end
        tx_q.delete();
        end_test();

        begin_test("underrun_disable");
        idle_val = rand_word();
        reg_access(1'b1, reg_addr_idle, idle_val, rd);
        exchange(rand_word(), idle_val, 1'b0, 1'b1);
        exp_ctrl.enable = 1'b0;
        reg_access(1'b1, reg_addr_ctrl, exp_ctrl, rd);
        w = rand_word();
        push_tx(w);
        repeat (6) @(negedge sys_clk);
        exchange(rand_word(), idle_val, 1'b0, 1'b0);
        // The held word goes out once enabled again.
        exp_ctrl.enable = 1'b1;
        reg_access(1'b1, reg_addr_ctrl, exp_ctrl, rd);
        exchange(rand_word(), w, 1'b0, 1'b1);
        end_test();

        begin_test("lsb_first");
        exp_ctrl.lsb_first = 1'b1;
        reg_access(1'b1, reg_addr_ctrl, exp_ctrl, rd);
        repeat (2) begin
            w = rand_word();
            tx_q.push_back(w);
            push_tx(w);
        end
        repeat (6) @(negedge sys_clk);
        foreach (tx_q[k]) begin
            exchange(rand_word(), tx_q[k], 1'b1, 1'b1);
        end
        exchange(rand_word(), idle_val, 1'b1, 1'b1);
        exp_ctrl.lsb_first = 1'b0;
        reg_access(1'b1, reg_addr_ctrl, exp_ctrl, rd);
        end_test();

        // Rx_ready stays low, the last two words find the FIFO full.
        begin_test("back_pressure");
        repeat (spi_fifo_depth + 2) begin
            w = rand_word();
            sent_q.push_back(w);
            spi_xfer(w, rd);
            check_word(idle_val, rd);
        end
        exp_status.rx_valid = 1'b1;
        reg_access(1'b0, reg_addr_status, '0, rd);
        check_word(exp_status, rd);
        for (int k = 0; k < spi_fifo_depth; k++) begin
            pop_rx(rd);
            check_word(sent_q[k], rd);
        end
        expect_no_rx(16);
        repeat (spi_fifo_depth) begin
            push_tx(rand_word());
        end
        check_cond(!tx_ready, "tx_ready still high with a full transmit FIFO");
        exp_status.rx_valid = 1'b0;
        exp_status.tx_ready = 1'b0;
        reg_access(1'b0, reg_addr_status, '0, rd);
        check_word(exp_status, rd);
        end_test();

        total_err = errors + UUT.u_props.fail_count;
        $display("Tests run %0d, failed %0d, checks %0d, errors %0d, assertion failures %0d",
                 tests_run, tests_failed, checks, errors, UUT.u_props.fail_count);
        if (total_err == 0 && tests_failed == 0) begin
            $display("SIMULATION PASSED");
        end else begin
            $display("SIMULATION FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* vlog.f */
rtl/spi_sub_pkg.sv
rtl/spi_async_fifo.sv
rtl/spi_rx_deserializer.sv
rtl/spi_tx_serializer.sv
rtl/spi_sub_core.sv
rtl/spi_sub_regs.sv
rtl/spi_sub_top.sv
tests/spi_sub_props.sv
tests/spi_sub_tb.sv
